//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = snake_tb
FILELIST  = snake.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the regression"
	@echo "make clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

//--- design/body_store.sv
`default_nettype none

module body_store
	import snake_geom_pkg::*;
	import snake_timing_pkg::*;
(
	input  logic     clock,
	input  logic     reset_n,
	input  logic     step,
	input  heading_t heading,
	output logic     step_taken,
	output logic     move_valid,
	output logic     move_erase,
	output coord_x_t tail_x,
	output coord_y_t tail_y,
	output coord_x_t head_x,
	output coord_y_t head_y
);

	typedef enum logic [2:0] {
		s_load,
		s_load_gap,
		s_idle,
		s_sample,
		s_read_tail,
		s_shift,
		s_head
	} state_t;

	state_t     state;
	seg_index_t idx;

	// segment memory, index 0 holds the head
	coord_x_t mem_x [snake_len];
	coord_y_t mem_y [snake_len];

	heading_t dir;
	coord_x_t load_x;
	coord_x_t next_x;
	coord_y_t next_y;

	assign step_taken = (state == s_sample);

	// initial body lies toward smaller x
	assign load_x = start_head_x - coord_x_t'(idx);

	// new head with wrap at every edge
	always_comb begin
		next_x = mem_x[0];
		next_y = mem_y[0];
		case (dir)
			heading_right:
				next_x = (mem_x[0] == coord_x_t'(screen_w - 1)) ? '0 : mem_x[0] + 1'b1;
			heading_left:
				next_x = (mem_x[0] == '0) ? coord_x_t'(screen_w - 1) : mem_x[0] - 1'b1;
			heading_down:
				next_y = (mem_y[0] == coord_y_t'(screen_h - 1)) ? '0 : mem_y[0] + 1'b1;
			heading_up:
				next_y = (mem_y[0] == '0) ? coord_y_t'(screen_h - 1) : mem_y[0] - 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			state      <= s_load;
			idx        <= '0;
			move_valid <= 1'b0;
		end else begin
			move_valid <= 1'b0;
			case (state)
				s_load: begin
					move_valid <= 1'b1;
					state      <= (idx == seg_index_t'(snake_len - 1)) ? s_idle : s_load_gap;
				end
				s_load_gap: begin
					idx   <= idx + 1'b1;
					state <= s_load;
				end
				s_idle: if (step) state <= s_sample;
				s_sample: state <= s_read_tail;
				s_read_tail: begin
					idx   <= seg_index_t'(snake_len - 1);
					state <= s_shift;
				end
				// walk from the tail end back to index one
				s_shift: begin
					if (idx == seg_index_t'(1))
						state <= s_head;
					else
						idx <= idx - 1'b1;
				end
				s_head: begin
					move_valid <= 1'b1;
					state      <= s_idle;
				end
				default: state <= s_idle;
			endcase
		end
	end

	// memory and record payload
	always_ff @(posedge clock) begin
		case (state)
			s_load: begin
				mem_x[idx] <= load_x;
				mem_y[idx] <= start_y;
				head_x     <= load_x;
				head_y     <= start_y;
				move_erase <= 1'b0;
			end
			s_sample: dir <= heading;
			s_read_tail: begin
				tail_x <= mem_x[snake_len - 1];
				tail_y <= mem_y[snake_len - 1];
			end
			s_shift: begin
				mem_x[idx] <= mem_x[idx - 1'b1];
				mem_y[idx] <= mem_y[idx - 1'b1];
			end
			s_head: begin
				mem_x[0]   <= next_x;
				mem_y[0]   <= next_y;
				head_x     <= next_x;
				head_y     <= next_y;
				move_erase <= 1'b1;
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

//--- design/heading_control.sv
`default_nettype none

module heading_control
	import snake_geom_pkg::*;
(
	input  logic     clock,
	input  logic     reset_n,
	input  heading_t turn,
	input  logic     step_taken,
	output heading_t heading
);

	heading_t stepped;
	heading_t ref_heading;
	logic     turn_legal;
	logic     turn_ok;

	function automatic logic is_horizontal(input heading_t h);
		is_horizontal = (h == heading_right) || (h == heading_left);
	endfunction

	// heading being sampled right now counts as the one in force
	assign ref_heading = step_taken ? heading : stepped;

	// only clean one-hot codes
	assign turn_legal = (turn == heading_right) || (turn == heading_down) ||
		(turn == heading_up) || (turn == heading_left);

	// perpendicular turns only, so reversals and repeats drop out
	assign turn_ok = turn_legal && (is_horizontal(turn) != is_horizontal(ref_heading));

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			heading <= heading_right;
			stepped <= heading_right;
		end else begin
			if (step_taken)
				stepped <= heading;
			if (turn_ok)
				heading <= turn;
		end
	end

endmodule

`default_nettype wire

//--- design/pixel_writer.sv
`default_nettype none

module pixel_writer
	import snake_geom_pkg::*;
(
	input  logic     clock,
	input  logic     reset_n,
	input  logic     move_valid,
	input  logic     move_erase,
	input  coord_x_t tail_x,
	input  coord_y_t tail_y,
	input  coord_x_t head_x,
	input  coord_y_t head_y,
	output logic     plot,
	output coord_x_t x,
	output coord_y_t y,
	output colour_t  colour
);

	// head held back while the tail erase goes out
	logic     draw_pending;
	coord_x_t held_x;
	coord_y_t held_y;

	always_ff @(posedge clock) begin
		if (!reset_n) begin
			plot         <= 1'b0;
			draw_pending <= 1'b0;
		end else if (move_valid) begin
			plot         <= 1'b1;
			draw_pending <= move_erase;
		end else begin
			plot         <= draw_pending;
			draw_pending <= 1'b0;
		end
	end

	always_ff @(posedge clock) begin
		if (move_valid) begin
			held_x <= head_x;
			held_y <= head_y;
			// erase first, otherwise straight to the head
			x      <= move_erase ? tail_x : head_x;
			y      <= move_erase ? tail_y : head_y;
			colour <= move_erase ? colour_blank : colour_body;
		end else if (draw_pending) begin
			x      <= held_x;
			y      <= held_y;
			colour <= colour_body;
		end
	end

endmodule

`default_nettype wire

//--- design/snake_geom_pkg.sv
`default_nettype none

package snake_geom_pkg;

	// visible area of the frame buffer
	localparam int screen_w = 160;
	localparam int screen_h = 120;

	// 8 bits cover 0..159, 7 bits cover 0..119
	typedef logic [7:0] coord_x_t;
	typedef logic [6:0] coord_y_t;

	// one-hot heading, one bit per direction
	typedef logic [3:0] heading_t;

	// x plus one
	localparam heading_t heading_right = 4'b0001;
	// y plus one
	localparam heading_t heading_down  = 4'b0010;
	// y minus one
	localparam heading_t heading_up    = 4'b0100;
	// x minus one
	localparam heading_t heading_left  = 4'b1000;

	// head at 24, body laid out toward smaller x
	localparam coord_x_t start_head_x = 8'd24;
	localparam coord_y_t start_y      = 7'd20;

	// 1 bit per channel, rgb
	typedef logic [2:0] colour_t;

	localparam colour_t colour_body  = 3'd2;
	localparam colour_t colour_blank = 3'd0;

endpackage

`default_nettype wire

//--- design/snake_timing_pkg.sv
`default_nettype none

package snake_timing_pkg;

	// clock cycles per game step
	// must exceed the initial load and one full move
	localparam int step_cycles = 64;

	// fixed body length, head included
	localparam int snake_len = 5;

	// index into the segment memory
	// 0 is the head, snake_len - 1 the tail
	typedef logic [2:0] seg_index_t;

endpackage

`default_nettype wire

//--- design/snake_top.sv
`default_nettype none

module snake_top
	import snake_geom_pkg::*;
(
	input  logic     clock,
	input  logic     reset_n,
	input  heading_t turn,
	output logic     plot,
	output coord_x_t x,
	output coord_y_t y,
	output colour_t  colour
);

	logic     step;
	logic     step_taken;
	heading_t heading;
	logic     move_valid;
	logic     move_erase;
	coord_x_t tail_x;
	coord_y_t tail_y;
	coord_x_t head_x;
	coord_y_t head_y;

	step_timer u_step_timer (
		.clock   (clock),
		.reset_n (reset_n),
		.step    (step)
	);

	heading_control u_heading_control (
		.clock      (clock),
		.reset_n    (reset_n),
		.turn       (turn),
		.step_taken (step_taken),
		.heading    (heading)
	);

	body_store u_body_store (
		.clock      (clock),
		.reset_n    (reset_n),
		.step       (step),
		.heading    (heading),
		.step_taken (step_taken),
		.move_valid (move_valid),
		.move_erase (move_erase),
		.tail_x     (tail_x),
		.tail_y     (tail_y),
		.head_x     (head_x),
		.head_y     (head_y)
	);

	// pixel stream is always accepted downstream
	pixel_writer u_pixel_writer (
		.clock      (clock),
		.reset_n    (reset_n),
		.move_valid (move_valid),
		.move_erase (move_erase),
		.tail_x     (tail_x),
		.tail_y     (tail_y),
		.head_x     (head_x),
		.head_y     (head_y),
		.plot       (plot),
		.x          (x),
		.y          (y),
		.colour     (colour)
	);

endmodule

`default_nettype wire

//--- design/step_timer.sv
`default_nettype none

module step_timer
	import snake_timing_pkg::*;
(
	input  logic clock,
	input  logic reset_n,
	output logic step
);

	logic [$clog2(step_cycles)-1:0] count;

	// down counter, pulse when it wraps through zero
	always_ff @(posedge clock) begin
		if (!reset_n) begin
			count <= ($clog2(step_cycles))'(step_cycles - 1);
			step  <= 1'b0;
		end else if (count == '0) begin
			count <= ($clog2(step_cycles))'(step_cycles - 1);
			step  <= 1'b1;
		end else begin
			count <= count - 1'b1;
			step  <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- snake.f
design/snake_geom_pkg.sv
design/snake_timing_pkg.sv
design/step_timer.sv
design/heading_control.sv
design/body_store.sv
design/pixel_writer.sv
design/snake_top.sv
verif/snake_tb.sv

//--- verif/snake_tb.sv
`default_nettype none

module snake_tb
	import snake_geom_pkg::*;
	import snake_timing_pkg::*;
();

	localparam int directed_steps = 4;
	localparam int random_steps   = 16;
	// worst case for both wrap runs plus the steering detours
	localparam int max_steps  = directed_steps + random_steps + screen_h + screen_w + 8;
	localparam int move_limit = step_cycles + 2 * snake_len + 8;

	logic     clock;
	logic     reset_n;
	heading_t turn;
	logic     plot;
	coord_x_t x;
	coord_y_t y;
	colour_t  colour;

	// reference body with the head at index 0
	int          seg_x [snake_len];
	int          seg_y [snake_len];
	heading_t    model_heading;
	heading_t    model_stepped;
	logic [31:0] rng;
	int          cycle;
	int          last_erase;
	string       test_name;
	logic        saw_x_wrap;
	logic        saw_y_wrap;

	snake_top u_snake_top (
		.clock   (clock),
		.reset_n (reset_n),
		.turn    (turn),
		.plot    (plot),
		.x       (x),
		.y       (y),
		.colour  (colour)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Regression failed");
		$fatal(1);
	endtask

	initial begin
		#((max_steps + 4) * step_cycles * 10 + 1000);
		stop_run("watchdog expired before all moves were seen");
	end

	task automatic check_value(input string name, input int expected, input int actual);
		assert (expected == actual)
		else stop_run($sformatf("Fail %s: expected %0d, actual %0d", name, expected, actual));
	endtask

	task automatic tick();
		@(posedge clock);
		#1;
		cycle++;
	endtask

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic logic moves_horizontally(input heading_t h);
		return h[0] | h[3];
	endfunction

	function automatic heading_t reverse_of(input heading_t h);
		case (h)
			heading_right: return heading_left;
			heading_left:  return heading_right;
			heading_up:    return heading_down;
			default:       return heading_up;
		endcase
	endfunction

	// direction of the head step or zero when it is not a single step
	function automatic heading_t observed_dir(input int ox, input int oy,
		input int nx, input int ny);
		if (ny == oy && nx == (ox + 1) % screen_w)
			return heading_right;
		if (ny == oy && nx == (ox + screen_w - 1) % screen_w)
			return heading_left;
		if (nx == ox && ny == (oy + 1) % screen_h)
			return heading_down;
		if (nx == ox && ny == (oy + screen_h - 1) % screen_h)
			return heading_up;
		return '0;
	endfunction

	task automatic wait_plot(input int limit, output int waited);
		waited = 0;
		do begin
			tick();
			waited++;
			if (waited > limit)
				stop_run($sformatf("no pixel write seen within %0d cycles", limit));
		end while (!plot);
	endtask

	// one-hot and perpendicular to the heading of the last move
	task automatic apply_turn(input heading_t code);
		if ($countones(code) == 1 &&
			moves_horizontally(code) != moves_horizontally(model_stepped)) begin
			model_heading = code;
			test_name     = "legal turn";
		end else begin
			test_name = "refused turn";
		end
		turn = code;
		tick();
		turn = '0;
	endtask

	task automatic do_move();
		int       ox;
		int       oy;
		int       nx;
		int       ny;
		int       waited;
		int       i;
		heading_t dir;
		dir           = model_heading;
		model_stepped = dir;
		ox = seg_x[0];
		oy = seg_y[0];
		nx = ox;
		ny = oy;
		case (dir)
			heading_right: nx = (ox + 1) % screen_w;
			heading_left:  nx = (ox + screen_w - 1) % screen_w;
			heading_down:  ny = (oy + 1) % screen_h;
			default:       ny = (oy + screen_h - 1) % screen_h;
		endcase
		wait_plot(move_limit, waited);
		check_value({test_name, " erase colour"}, colour_blank, colour);
		check_value({test_name, " erase x"}, seg_x[snake_len - 1], x);
		check_value({test_name, " erase y"}, seg_y[snake_len - 1], y);
		if (last_erase > 0)
			check_value({test_name, " step period"}, step_cycles, cycle - last_erase);
		last_erase = cycle;
		// head draw follows in the very next cycle
		tick();
		check_value({test_name, " draw strobe"}, 1, plot);
		check_value({test_name, " draw colour"}, colour_body, colour);
		check_value({test_name, " direction"}, dir, observed_dir(ox, oy, x, y));
		check_value({test_name, " head x"}, nx, x);
		check_value({test_name, " head y"}, ny, y);
		if (dir == heading_right && ox == screen_w - 1)
			saw_x_wrap = 1'b1;
		if (dir == heading_up && oy == 0)
			saw_y_wrap = 1'b1;
		for (i = snake_len - 1; i > 0; i--) begin
			seg_x[i] = seg_x[i - 1];
			seg_y[i] = seg_y[i - 1];
		end
		seg_x[0] = nx;
		seg_y[0] = ny;
	endtask

	task automatic random_turns();
		heading_t code;
		rng = xorshift32(rng);
		repeat (2 + rng[3:0]) tick();
		case (rng[9:8])
			2'd0: code = rng[7:4];
			2'd1: code = reverse_of(model_stepped);
			2'd2: code = moves_horizontally(model_stepped) ?
				(rng[4] ? heading_up : heading_down) : (rng[4] ? heading_right : heading_left);
			default: code = '0;
		endcase
		apply_turn(code);
		// second turn before the same step
		if (rng[12]) begin
			repeat (2) tick();
			apply_turn(rng[13] ? reverse_of(model_stepped) : heading_t'(rng[19:16]));
		end
	endtask

	// get onto target by way of one detour move when target is a reversal
	task automatic steer(input heading_t target, input heading_t detour);
		if (model_stepped == reverse_of(target)) begin
			apply_turn(detour);
			do_move();
		end
		if (model_stepped != target)
			apply_turn(target);
	endtask

	initial begin
		int i;
		int waited;
		reset_n    = 1'b0;
		turn       = '0;
		rng        = 32'h3aa6;
		cycle      = 0;
		last_erase = 0;
		saw_x_wrap = 1'b0;
		saw_y_wrap = 1'b0;
		test_name  = "reset idle";
		repeat (16) begin
			tick();
			check_value(test_name, 0, plot);
		end
		reset_n = 1'b1;
		tick();
		check_value(test_name, 0, plot);

		test_name = "initial draw";
		for (i = 0; i < snake_len; i++) begin
			wait_plot(4, waited);
			if (i > 0)
				check_value({test_name, " spacing"}, 2, waited);
			check_value({test_name, " colour"}, colour_body, colour);
			check_value({test_name, " x"}, start_head_x - i, x);
			check_value({test_name, " y"}, start_y, y);
			seg_x[i] = start_head_x - i;
			seg_y[i] = start_y;
		end
		model_heading = heading_right;
		model_stepped = heading_right;

		// zero code, two bits set, reversal, then down followed by a late left
		apply_turn('0);
		do_move();
		apply_turn(4'b0011);
		do_move();
		apply_turn(heading_left);
		do_move();
		apply_turn(heading_down);
		apply_turn(heading_left);
		do_move();

		for (i = 0; i < random_steps; i++) begin
			random_turns();
			do_move();
		end

		steer(heading_up, heading_right);
		test_name = "edge wrap y";
		for (i = 0; i <= screen_h && !saw_y_wrap; i++)
			do_move();

		steer(heading_right, heading_up);
		test_name = "edge wrap x";
		for (i = 0; i <= screen_w && !saw_x_wrap; i++)
			do_move();

		$display("Regression passed");
		$finish;
	end

endmodule

`default_nettype wire
